// File: basic_dsp_top.f
common/reg_file_pkg.sv
common/dsp_pkg.sv
src/operand_capture.sv
mult_lane/mult_lane.sv
src/result_packer.sv
src/basic_dsp_top.sv
tests/basic_dsp_tb.sv

// File: common/dsp_pkg.sv
/*
 * Multiplier sizes and the product word shared by the lanes and the packer.
 * Compile after reg_file_pkg, since the lane count and the product halves
 * follow the register-file geometry.
 */

`default_nettype none

package dsp_pkg;

   // One lane per pair of host words, so the file of eight words feeds four lanes
   localparam int NUM_LANES = reg_file_pkg::REG_FILE_IO_SIZE / 2;

   // Unsigned operand width, the native size of one 27x27 DSP multiplier
   localparam int OPERAND_W = 27;

   // Full product width, which never overflows for unsigned operands
   localparam int PRODUCT_W = 2 * OPERAND_W;

   // Clock edges from lane inputs to lane product output
   // Stage one holds the operands and stage two holds the product
   localparam int LANE_LATENCY = 2;

   // A product word spans two host words
   localparam int PRODUCT_WORD_W = 2 * reg_file_pkg::HOST_WORD_W;

   // Host view of a product, the high word first so it lands in the upper bits
   typedef struct packed {
      logic [reg_file_pkg::HOST_WORD_W-1:0] hi;
      logic [reg_file_pkg::HOST_WORD_W-1:0] lo;
   } product_halves_t;

   // The lane writes the whole product and the packer reads it as two words
   // The top PRODUCT_WORD_W - PRODUCT_W bits are always zero
   typedef union packed {
      logic [PRODUCT_WORD_W-1:0] product;
      product_halves_t           halves;
   } product_word_u;

endpackage : dsp_pkg

`default_nettype wire

// File: common/reg_file_pkg.sv
/*
 * Register-file geometry shared with the host side of the persona.
 * The host sees eight words in each direction, all 32 bits wide.
 * Only bit CTRL_CLR_BIT of the control register is used by this persona.
 */

`default_nettype none

package reg_file_pkg;

   // Number of host-to-logic words, and also of logic-to-host words
   localparam int REG_FILE_IO_SIZE = 8;

   // Width of every register-file word as seen over the host bus
   localparam int HOST_WORD_W = 32;

   // Read-only value the host program checks before it uses the persona
   // A different persona must report a different word here
   localparam logic [HOST_WORD_W-1:0] PERSONA_ID = 32'h0000_aeed;

   // Bit of the host control register that requests a software clear
   // The clear fires on the 0 to 1 transition only, not on the level
   localparam int CTRL_CLR_BIT = 0;

endpackage : reg_file_pkg

`default_nettype wire

// File: mult_lane/mult_lane.sv
/*
 * One unsigned 27x27 multiplier lane, two register stages deep.
 * A new operand pair is accepted every cycle and there is no stall.
 * The clear input zeroes both stages in step with the rest of the pipe.
 */

`default_nettype none

module mult_lane (
   input  logic                          clk,
   input  logic                          pr_logic_rst,
   input  logic                          clr,
   input  logic [dsp_pkg::OPERAND_W-1:0] ax,
   input  logic [dsp_pkg::OPERAND_W-1:0] ay,
   output dsp_pkg::product_word_u        product
);

   import dsp_pkg::*;

   // Stage one operand registers, the input registers of a DSP block
   logic [OPERAND_W-1:0] ax_q;
   logic [OPERAND_W-1:0] ay_q;

   // Full product of the stage one operands
   logic [PRODUCT_W-1:0] full_product;

   // Stage one
   always_ff @(posedge clk) begin
      if (pr_logic_rst || clr) begin
         ax_q <= '0;
         ay_q <= '0;
      end else begin
         ax_q <= ax;
         ay_q <= ay;
      end
   end

   // Both operands are unsigned and the result is sized to PRODUCT_W,
   // so the multiply is done at full width and cannot overflow
   always_comb begin
      full_product = ax_q * ay_q;
   end

   // Stage two, the output register of the DSP block
   // The clear takes the place of the block's own asynchronous clear, in synchronous form
   always_ff @(posedge clk) begin
      if (pr_logic_rst || clr) begin
         product <= '0;
      end else begin
         // Zero-extend into the 64-bit view so the upper pad bits stay 0
         product.product <= PRODUCT_WORD_W'(full_product);
      end
   end

   // A clear on one edge shows as a zero product for LANE_LATENCY cycles,
   // since the cleared stage one feeds a zero into stage two on the next edge

endmodule : mult_lane

`default_nettype wire

// File: src/basic_dsp_top.sv
/*
 * Persona top. The host writes operand pairs into host_pr and reads the products
 * from pr_host four cycles later. A 0 to 1 change on bit 0 of host_cntrl_register
 * clears the pipe and is passed out on clr_io_reg for the host register file.
 */

`default_nettype none

module basic_dsp_top (
   input  logic                                 clk,
   input  logic                                 pr_logic_rst,
   input  logic [reg_file_pkg::HOST_WORD_W-1:0] host_cntrl_register,
   input  logic [reg_file_pkg::HOST_WORD_W-1:0] host_pr [0:reg_file_pkg::REG_FILE_IO_SIZE-1],
   output logic [reg_file_pkg::HOST_WORD_W-1:0] pr_host [0:reg_file_pkg::REG_FILE_IO_SIZE-1],
   output logic [reg_file_pkg::HOST_WORD_W-1:0] persona_id,
   output logic                                 clr_io_reg
);

   import reg_file_pkg::*;
   import dsp_pkg::*;

   // Registered lane operands from the capture stage
   logic [OPERAND_W-1:0] ax [0:NUM_LANES-1];
   logic [OPERAND_W-1:0] ay [0:NUM_LANES-1];

   // Lane products, written as one product and read as two host words
   product_word_u lane_product [0:NUM_LANES-1];

   // The host program reads this to find out which persona is loaded
   assign persona_id = PERSONA_ID;

   // Clear pulse generation and operand registers, one cycle
   operand_capture u_capture (
      .clk                 (clk),
      .pr_logic_rst        (pr_logic_rst),
      .host_cntrl_register (host_cntrl_register),
      .host_pr             (host_pr),
      .clr_io_reg          (clr_io_reg),
      .ax                  (ax),
      .ay                  (ay)
   );

   // Multiplier lanes, LANE_LATENCY cycles each
   // All lanes share the clear so the whole pipe empties on the same edge
   for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
      mult_lane u_lane (
         .clk          (clk),
         .pr_logic_rst (pr_logic_rst),
         .clr          (clr_io_reg),
         .ax           (ax[k]),
         .ay           (ay[k]),
         .product      (lane_product[k])
      );
   end

   // Output registers toward the host, one cycle
   result_packer u_packer (
      .clk          (clk),
      .pr_logic_rst (pr_logic_rst),
      .clr          (clr_io_reg),
      .products     (lane_product),
      .pr_host      (pr_host)
   );

endmodule : basic_dsp_top

`default_nettype wire

// File: src/operand_capture.sv
/*
 * Turns the host control bit into a one-cycle clear pulse and registers
 * the lane operands. Only the low OPERAND_W bits of each host word are kept,
 * and a host word pair 2k, 2k+1 always feeds lane k.
 */

`default_nettype none

module operand_capture (
   input  logic                                clk,
   input  logic                                pr_logic_rst,
   input  logic [reg_file_pkg::HOST_WORD_W-1:0] host_cntrl_register,
   input  logic [reg_file_pkg::HOST_WORD_W-1:0] host_pr [0:reg_file_pkg::REG_FILE_IO_SIZE-1],
   output logic                                clr_io_reg,
   output logic [dsp_pkg::OPERAND_W-1:0]        ax [0:dsp_pkg::NUM_LANES-1],
   output logic [dsp_pkg::OPERAND_W-1:0]        ay [0:dsp_pkg::NUM_LANES-1]
);

   import reg_file_pkg::*;
   import dsp_pkg::*;

   // Control bit as sampled on the previous edge
   logic clr_bit_q;

   // Rising-edge detector on the clear bit
   // The pulse is registered, so it shows one cycle after the bit is sampled at 1
   always_ff @(posedge clk) begin
      if (pr_logic_rst) begin
         clr_bit_q  <= 1'b0;
         clr_io_reg <= 1'b0;
      end else begin
         clr_bit_q  <= host_cntrl_register[CTRL_CLR_BIT];
         // Holding the bit high gives a single pulse; it must drop to 0 to rearm
         clr_io_reg <= host_cntrl_register[CTRL_CLR_BIT] & ~clr_bit_q;
      end
   end

   // Operand registers, reloaded every cycle with no handshake
   always_ff @(posedge clk) begin
      if (pr_logic_rst || clr_io_reg) begin
         // Software clear zeroes the operands together with the rest of the pipe
         for (int k = 0; k < NUM_LANES; k++) begin
            ax[k] <= '0;
            ay[k] <= '0;
         end
      end else begin
         for (int k = 0; k < NUM_LANES; k++) begin
            // Even word is the x operand, odd word the y operand
            // Bits above OPERAND_W are dropped here
            ax[k] <= host_pr[2*k][OPERAND_W-1:0];
            ay[k] <= host_pr[2*k+1][OPERAND_W-1:0];
         end
      end
   end

endmodule : operand_capture

`default_nettype wire

// File: src/result_packer.sv
/*
 * Registers the lane products into the logic-to-host words.
 * Lane k fills word 2k with the low half and word 2k+1 with the high half.
 * The host may read these words on any cycle.
 */

`default_nettype none

module result_packer (
   input  logic                                 clk,
   input  logic                                 pr_logic_rst,
   input  logic                                 clr,
   input  dsp_pkg::product_word_u               products [0:dsp_pkg::NUM_LANES-1],
   output logic [reg_file_pkg::HOST_WORD_W-1:0] pr_host [0:reg_file_pkg::REG_FILE_IO_SIZE-1]
);

   import reg_file_pkg::*;
   import dsp_pkg::*;

   // Host words split from the lane products, ahead of the output registers
   logic [HOST_WORD_W-1:0] pr_host_d [0:REG_FILE_IO_SIZE-1];

   // The lane writes the union as one product
   // Here the same word is read back as a high and a low host word
   always_comb begin
      for (int k = 0; k < NUM_LANES; k++) begin
         // High word carries only 22 product bits, the rest are the zero pad
         pr_host_d[2*k]   = products[k].halves.lo;
         pr_host_d[2*k+1] = products[k].halves.hi;
      end
   end

   // Output registers, the last stage before the host
   always_ff @(posedge clk) begin
      if (pr_logic_rst || clr) begin
         for (int w = 0; w < REG_FILE_IO_SIZE; w++) begin
            pr_host[w] <= '0;
         end
      end else begin
         for (int w = 0; w < REG_FILE_IO_SIZE; w++) begin
            pr_host[w] <= pr_host_d[w];
         end
      end
   end

endmodule : result_packer

`default_nettype wire

// File: tests/basic_dsp_tb.sv
/*
 * Testbench for basic_dsp_top. Random operands come from an LCG with a fixed seed.
 * A four-deep line of expected host words runs beside the DUT and is checked every cycle.
 */

`default_nettype none

module basic_dsp_tb;

   import reg_file_pkg::*;
   import dsp_pkg::*;

   localparam int CLK_PERIOD  = 10;
   localparam int N_RANDOM    = 400;
   localparam int N_CLEARS    = 3;
   localparam int MAX_GAP     = 15;
   // Worst-case stimulus length, summed over all tests
   localparam int TOTAL_CYCLES = 4 + N_RANDOM + 26 + 37 + N_CLEARS * (2 + MAX_GAP) + 12;
   localparam int MARGIN      = 200;

   logic                   clk;
   logic                   pr_logic_rst;
   logic [HOST_WORD_W-1:0] host_cntrl_register;
   logic [HOST_WORD_W-1:0] host_pr [0:REG_FILE_IO_SIZE-1];
   logic [HOST_WORD_W-1:0] pr_host [0:REG_FILE_IO_SIZE-1];
   logic [HOST_WORD_W-1:0] persona_id;
   logic                   clr_io_reg;

   // Expected host words, entry 0 is the capture stage and entry 3 is pr_host
   logic [HOST_WORD_W-1:0] exp_line [0:3][0:REG_FILE_IO_SIZE-1];
   logic                   bit_q_m;
   logic                   clr_m;

   logic [31:0] rng_state = 32'ha8fad2a6;
   logic        check_en = 1'b0;
   int          err_count = 0;
   int          pulse_count = 0;
   int          zero_checks = 0;
   int          zero_left = 0;
   int          tests_ok = 0;
   int          tests_bad = 0;

   basic_dsp_top DUT (
      .clk                 (clk),
      .pr_logic_rst        (pr_logic_rst),
      .host_cntrl_register (host_cntrl_register),
      .host_pr             (host_pr),
      .pr_host             (pr_host),
      .persona_id          (persona_id),
      .clr_io_reg          (clr_io_reg)
   );

   initial begin
      clk = 1'b0;
   end

   always #(CLK_PERIOD / 2) clk = ~clk;

   // LCG step, the output is folded so the weak low bits still change
   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state ^ (rng_state >> 15);
   endfunction

   // Reference pipeline. Every stage loads zero on reset or on the expected pulse
   always @(posedge clk) begin : model_step
      logic [63:0] prod;
      if (pr_logic_rst) begin
         bit_q_m <= 1'b0;
         clr_m   <= 1'b0;
         for (int d = 0; d < 4; d++)
            for (int w = 0; w < REG_FILE_IO_SIZE; w++)
               exp_line[d][w] <= '0;
      end else begin
         bit_q_m <= host_cntrl_register[CTRL_CLR_BIT];
         // Pulse only on a sampled 0 to 1 change of the control bit
         clr_m   <= host_cntrl_register[CTRL_CLR_BIT] & ~bit_q_m;
         if (clr_m) begin
            for (int d = 0; d < 4; d++)
               for (int w = 0; w < REG_FILE_IO_SIZE; w++)
                  exp_line[d][w] <= '0;
         end else begin
            for (int d = 3; d > 0; d--)
               for (int w = 0; w < REG_FILE_IO_SIZE; w++)
                  exp_line[d][w] <= exp_line[d-1][w];
            for (int k = 0; k < NUM_LANES; k++) begin
               // The 64-bit target widens both 27-bit operands before the multiply
               prod = host_pr[2*k][OPERAND_W-1:0] * host_pr[2*k+1][OPERAND_W-1:0];
               exp_line[0][2*k]   <= prod[31:0];
               exp_line[0][2*k+1] <= prod[63:32];
            end
         end
      end
   end

   // Outputs are compared at the falling edge, half a cycle after they settle
   always @(negedge clk) begin
      if (check_en) begin
         if (clr_io_reg !== clr_m) begin
            $display("ERR clr_io_reg expected %h actual %h", clr_m, clr_io_reg);
            err_count++;
         end
         if (persona_id !== PERSONA_ID) begin
            $display("ERR persona_id expected %h actual %h", PERSONA_ID, persona_id);
            err_count++;
         end
         for (int w = 0; w < REG_FILE_IO_SIZE; w++) begin
            if (pr_host[w] !== exp_line[3][w]) begin
               $display("ERR pr_host[%0d] expected %h actual %h", w, exp_line[3][w], pr_host[w]);
               err_count++;
            end
         end
         // Each pulse must be followed by four all-zero reads of pr_host
         if (clr_io_reg) begin
            pulse_count++;
            zero_left = 4;
         end else if (zero_left > 0) begin
            for (int w = 0; w < REG_FILE_IO_SIZE; w++) begin
               if (pr_host[w] !== '0) begin
                  $display("ERR pr_host[%0d] expected %h actual %h", w, 32'h0, pr_host[w]);
                  err_count++;
               end
            end
            zero_checks++;
            zero_left--;
         end
      end
   end

   // One cycle of fresh random operands; mask bits are forced high in every word
   task automatic drive_cycle(input logic clr_bit, input logic [31:0] force_mask);
      logic [31:0] ctrl_rand;
      @(posedge clk);
      for (int w = 0; w < REG_FILE_IO_SIZE; w++)
         host_pr[w] <= next_rand() | force_mask;
      ctrl_rand = next_rand();
      // Upper control bits are noise and must not matter
      host_cntrl_register <= {ctrl_rand[31:1], clr_bit};
   endtask

   task automatic report_test(input string name, input int start_errs);
      if (err_count == start_errs) begin
         tests_ok++;
         $display("%s: ok", name);
      end else begin
         tests_bad++;
         $display("%s: %0d errors", name, err_count - start_errs);
      end
   endtask

   initial begin : run_tests
      int          start_errs;
      int          start_count;
      int          gap;
      logic [31:0] r;
      pr_logic_rst        = 1'b1;
      host_cntrl_register = '0;
      for (int w = 0; w < REG_FILE_IO_SIZE; w++)
         host_pr[w] = '0;
      repeat (3) @(posedge clk);
      pr_logic_rst <= 1'b0;
      check_en = 1'b1;

      // Reset state, checked against fixed values
      start_errs = err_count;
      @(negedge clk);
      for (int w = 0; w < REG_FILE_IO_SIZE; w++) begin
         if (pr_host[w] !== '0) begin
            $display("ERR pr_host[%0d] expected %h actual %h", w, 32'h0, pr_host[w]);
            err_count++;
         end
      end
      if (clr_io_reg !== 1'b0) begin
         $display("ERR clr_io_reg expected %h actual %h", 1'b0, clr_io_reg);
         err_count++;
      end
      report_test("reset_values", start_errs);

      // Long random run, new operands every cycle
      start_errs = err_count;
      repeat (N_RANDOM) drive_cycle(1'b0, 32'h0);
      report_test("random_products", start_errs);

      // Bits 27 to 31 set, then all-ones words
      start_errs = err_count;
      repeat (20) drive_cycle(1'b0, 32'hf800_0000);
      repeat (6) drive_cycle(1'b0, 32'hffff_ffff);
      @(negedge clk);
      // (2^27-1)^2 = 2^54 - 2^28 + 1, so hi is 003fffff and lo is f0000001
      for (int k = 0; k < NUM_LANES; k++) begin
         if (pr_host[2*k+1] !== 32'h003f_ffff) begin
            $display("ERR pr_host[%0d] expected %h actual %h", 2*k+1, 32'h003f_ffff,
                     pr_host[2*k+1]);
            err_count++;
         end
         if (pr_host[2*k] !== 32'hf000_0001) begin
            $display("ERR pr_host[%0d] expected %h actual %h", 2*k, 32'hf000_0001,
                     pr_host[2*k]);
            err_count++;
         end
      end
      report_test("operand_edges", start_errs);

      // Level held high must give one pulse, and rearm only after a low
      start_errs = err_count;
      start_count = pulse_count;
      repeat (20) drive_cycle(1'b1, 32'h0);
      repeat (3) drive_cycle(1'b0, 32'h0);
      if (pulse_count - start_count != 1) begin
         $display("clear bit held high gave %0d pulses instead of one",
                  pulse_count - start_count);
         err_count++;
      end
      repeat (10) drive_cycle(1'b1, 32'h0);
      repeat (4) drive_cycle(1'b0, 32'h0);
      if (pulse_count - start_count != 2) begin
         $display("second rising edge of the clear bit gave %0d pulses in total instead of two",
                  pulse_count - start_count);
         err_count++;
      end
      report_test("clear_pulse_shape", start_errs);

      // Short clear requests in random gaps while operands keep flowing
      start_errs = err_count;
      start_count = zero_checks;
      for (int i = 0; i < N_CLEARS; i++) begin
         repeat (2) drive_cycle(1'b1, 32'h0);
         r = next_rand();
         gap = 8 + (r % 8);
         repeat (gap) drive_cycle(1'b0, 32'h0);
      end
      repeat (10) drive_cycle(1'b0, 32'h0);
      if (zero_checks - start_count != 4 * N_CLEARS) begin
         $display("expected %0d zero reads after the clears but saw %0d",
                  4 * N_CLEARS, zero_checks - start_count);
         err_count++;
      end
      report_test("clear_effect", start_errs);

      @(negedge clk);
      $display("tests ok: %0d, tests with errors: %0d, error lines: %0d",
               tests_ok, tests_bad, err_count);
      if (tests_bad == 0 && err_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog sized from the stimulus length
   initial begin
      #((TOTAL_CYCLES + MARGIN) * CLK_PERIOD);
      $display("timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES + MARGIN);
      $display("Test failed");
      $finish;
   end

endmodule : basic_dsp_tb

`default_nettype wire
